// ==== miq_pkg.sv ====
`default_nettype none

package miq_pkg;

    // ====================================================================
    // Queue geometry
    // ====================================================================
    localparam int ENTRIES    = 4;
    localparam int AGE_W      = 2;   // Ages run 0 to ENTRIES-1 and 0 is the oldest.
    localparam int WAKE_PORTS = 2;

    // ====================================================================
    // Instruction fields
    // ====================================================================
    localparam int IID_W    = 5;
    localparam int PREG_W   = 6;
    localparam int OPCODE_W = 7;
    localparam int FUNCT7_W = 7;
    localparam int FUNCT3_W = 3;

    // Divide and remainder share funct3 bit 2 in the M extension.
    localparam int DIV_BIT = 2;

endpackage

`default_nettype wire

// ==== miq_create_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface miq_create_if;

    logic [miq_pkg::ENTRIES-1:0]  create_vld;   // One-hot target slot.
    logic [miq_pkg::IID_W-1:0]    iid;
    logic [miq_pkg::OPCODE_W-1:0] opcode;
    logic [miq_pkg::FUNCT7_W-1:0] funct7;
    logic [miq_pkg::FUNCT3_W-1:0] funct3;
    logic                         psrc1_vld;
    logic                         psrc1_ready;
    logic [miq_pkg::PREG_W-1:0]   psrc1;
    logic                         psrc2_vld;
    logic                         psrc2_ready;
    logic [miq_pkg::PREG_W-1:0]   psrc2;
    logic                         pdst_vld;
    logic [miq_pkg::PREG_W-1:0]   pdst;

    modport dispatch (
        output create_vld, iid, opcode, funct7, funct3,
        output psrc1_vld, psrc1_ready, psrc1, psrc2_vld, psrc2_ready, psrc2,
        output pdst_vld, pdst
    );

    modport entries (
        input create_vld, iid, opcode, funct7, funct3,
        input psrc1_vld, psrc1_ready, psrc1, psrc2_vld, psrc2_ready, psrc2,
        input pdst_vld, pdst
    );

endinterface

`default_nettype wire

// ==== miq_entry_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface miq_entry_if (
    input logic clk
);

    // Per-entry state with one row per slot.
    logic [miq_pkg::ENTRIES-1:0]                        vld;
    logic [miq_pkg::ENTRIES-1:0]                        ready;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::AGE_W-1:0]    age;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::IID_W-1:0]    iid;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::OPCODE_W-1:0] opcode;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::FUNCT7_W-1:0] funct7;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::FUNCT3_W-1:0] funct3;
    logic [miq_pkg::ENTRIES-1:0]                        psrc1_vld;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::PREG_W-1:0]   psrc1;
    logic [miq_pkg::ENTRIES-1:0]                        psrc2_vld;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::PREG_W-1:0]   psrc2;
    logic [miq_pkg::ENTRIES-1:0]                        pdst_vld;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::PREG_W-1:0]   pdst;

    logic [miq_pkg::ENTRIES-1:0]                        issue_vld;   // Grant that is one-hot or zero.

    modport entries (
        input  clk, issue_vld,
        output vld, ready, age, iid, opcode, funct7, funct3,
        output psrc1_vld, psrc1, psrc2_vld, psrc2, pdst_vld, pdst
    );

    modport select (
        input  clk, vld, ready, age, iid, opcode, funct7, funct3,
        input  psrc1_vld, psrc1, psrc2_vld, psrc2, pdst_vld, pdst,
        output issue_vld
    );

endinterface

`default_nettype wire

// ==== miq_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module miq_dispatch (
    input  logic                         clk,
    input  logic                         rst_clk,
    input  logic                         dispatch_vld,
    input  logic                         dispatch_stall,
    input  logic [miq_pkg::IID_W-1:0]    dispatch_iid,
    input  logic [miq_pkg::OPCODE_W-1:0] dispatch_opcode,
    input  logic [miq_pkg::FUNCT7_W-1:0] dispatch_funct7,
    input  logic [miq_pkg::FUNCT3_W-1:0] dispatch_funct3,
    input  logic                         dispatch_psrc1_vld,
    input  logic                         dispatch_psrc1_ready,
    input  logic [miq_pkg::PREG_W-1:0]   dispatch_psrc1,
    input  logic                         dispatch_psrc2_vld,
    input  logic                         dispatch_psrc2_ready,
    input  logic [miq_pkg::PREG_W-1:0]   dispatch_psrc2,
    input  logic                         dispatch_pdst_vld,
    input  logic [miq_pkg::PREG_W-1:0]   dispatch_pdst,
    input  logic [miq_pkg::ENTRIES-1:0]  entry_vld,
    output logic                         full,
    miq_create_if.dispatch               cr
);

    logic                        accept;
    logic [miq_pkg::ENTRIES-1:0] free_sel;

    assign full   = &entry_vld;
    assign accept = dispatch_vld & ~full & ~dispatch_stall;

    // Isolates the lowest clear bit of the valid vector.
    assign free_sel      = ~entry_vld & (entry_vld + 1'b1);
    assign cr.create_vld = free_sel & {miq_pkg::ENTRIES{accept}};

    assign cr.iid         = dispatch_iid;
    assign cr.opcode      = dispatch_opcode;
    assign cr.funct7      = dispatch_funct7;
    assign cr.funct3      = dispatch_funct3;
    assign cr.psrc1_vld   = dispatch_psrc1_vld;
    assign cr.psrc1_ready = dispatch_psrc1_ready;
    assign cr.psrc1       = dispatch_psrc1;
    assign cr.psrc2_vld   = dispatch_psrc2_vld;
    assign cr.psrc2_ready = dispatch_psrc2_ready;
    assign cr.psrc2       = dispatch_psrc2;
    assign cr.pdst_vld    = dispatch_pdst_vld;
    assign cr.pdst        = dispatch_pdst;

    // The entry array must never see a create on a slot it still holds.
    a_create_free: assert property (@(posedge clk) disable iff (!rst_clk)
        (cr.create_vld & entry_vld) == '0);

endmodule

`default_nettype wire

// ==== miq_entries.sv ====
`timescale 1ns/1ps
`default_nettype none

module miq_entries (
    input  logic                                             clk,
    input  logic                                             rst_clk,
    input  logic                                             flush,
    input  logic [miq_pkg::WAKE_PORTS-1:0]                   wake_vld,
    input  logic [miq_pkg::WAKE_PORTS-1:0][miq_pkg::PREG_W-1:0] wake_preg,
    output logic [miq_pkg::ENTRIES-1:0]                      entry_vld,
    miq_create_if.entries                                    cr,
    miq_entry_if.entries                                     ef
);

    logic [miq_pkg::ENTRIES-1:0]                     vld;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::AGE_W-1:0] age;
    logic [miq_pkg::ENTRIES-1:0]                     rdy1;
    logic [miq_pkg::ENTRIES-1:0]                     rdy2;
    logic [miq_pkg::AGE_W:0]                         cnt;
    logic [miq_pkg::AGE_W-1:0]                       issue_age;
    logic [miq_pkg::AGE_W-1:0]                       new_age;
    logic                                            any_issue;
    logic                                            age_clash;

    function automatic logic woken(input logic [miq_pkg::PREG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < miq_pkg::WAKE_PORTS; p++)
            hit = hit | (wake_vld[p] && (wake_preg[p] == tag));
        return hit;
    endfunction

    // ====================================================================
    // Occupancy and age of the issued entry
    // ====================================================================
    always_comb
    begin
        cnt       = '0;
        issue_age = '0;
        for (int i = 0; i < miq_pkg::ENTRIES; i++)
        begin
            cnt       = cnt + {{miq_pkg::AGE_W{1'b0}}, vld[i]};
            issue_age = issue_age | (age[i] & {miq_pkg::AGE_W{ef.issue_vld[i]}});
        end
    end

    assign any_issue = |ef.issue_vld;
    // A create beside an issue lands one slot lower so the order stays dense.
    assign new_age   = miq_pkg::AGE_W'(cnt - {{miq_pkg::AGE_W{1'b0}}, any_issue});

    // ====================================================================
    // Entry state
    // ====================================================================
    always_ff @(posedge clk or negedge rst_clk)
    begin
        if (!rst_clk)
        begin
            vld  <= '0;
            age  <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end
        else
        begin
            for (int i = 0; i < miq_pkg::ENTRIES; i++)
            begin
                if (flush)
                    vld[i] <= 1'b0;
                else if (cr.create_vld[i])
                begin
                    vld[i]  <= 1'b1;
                    age[i]  <= new_age;
                    rdy1[i] <= cr.psrc1_ready | woken(cr.psrc1);
                    rdy2[i] <= cr.psrc2_ready | woken(cr.psrc2);
                end
                else
                begin
                    if (ef.issue_vld[i])
                        vld[i] <= 1'b0;
                    else if (any_issue && (age[i] > issue_age))
                        age[i] <= age[i] - 1'b1;   // Close the gap left by the issue.
                    if (woken(ef.psrc1[i]))
                        rdy1[i] <= 1'b1;
                    if (woken(ef.psrc2[i]))
                        rdy2[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < miq_pkg::ENTRIES; i++)
        begin
            if (cr.create_vld[i])
            begin
                ef.iid[i]       <= cr.iid;
                ef.opcode[i]    <= cr.opcode;
                ef.funct7[i]    <= cr.funct7;
                ef.funct3[i]    <= cr.funct3;
                ef.psrc1_vld[i] <= cr.psrc1_vld;
                ef.psrc1[i]     <= cr.psrc1;
                ef.psrc2_vld[i] <= cr.psrc2_vld;
                ef.psrc2[i]     <= cr.psrc2;
                ef.pdst_vld[i]  <= cr.pdst_vld;
                ef.pdst[i]      <= cr.pdst;
            end
        end
    end

    assign entry_vld = vld;
    assign ef.vld    = vld;
    assign ef.age    = age;
    assign ef.ready  = vld & (~ef.psrc1_vld | rdy1) & (~ef.psrc2_vld | rdy2);

    always_comb
    begin
        age_clash = 1'b0;
        for (int i = 0; i < miq_pkg::ENTRIES; i++)
            for (int j = i + 1; j < miq_pkg::ENTRIES; j++)
                if (vld[i] && vld[j] && (age[i] == age[j]))
                    age_clash = 1'b1;
    end

    a_age_distinct: assert property (@(posedge clk) disable iff (!rst_clk) !age_clash);
    a_issue_valid:  assert property (@(posedge clk) disable iff (!rst_clk)
        (ef.issue_vld & ~vld) == '0);

endmodule

`default_nettype wire

// ==== miq_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module miq_select (
    input  logic                         div_stall_exu,
    input  logic                         div_stall_idu,
    miq_entry_if.select                  ef,
    output logic                         issue_vld,
    output logic [miq_pkg::IID_W-1:0]    issue_iid,
    output logic [miq_pkg::OPCODE_W-1:0] issue_opcode,
    output logic [miq_pkg::FUNCT7_W-1:0] issue_funct7,
    output logic [miq_pkg::FUNCT3_W-1:0] issue_funct3,
    output logic                         issue_psrc1_vld,
    output logic [miq_pkg::PREG_W-1:0]   issue_psrc1,
    output logic                         issue_psrc2_vld,
    output logic [miq_pkg::PREG_W-1:0]   issue_psrc2,
    output logic                         issue_pdst_vld,
    output logic [miq_pkg::PREG_W-1:0]   issue_pdst
);

    logic [miq_pkg::ENTRIES-1:0]                   grant;
    logic [miq_pkg::ENTRIES-1:0][miq_pkg::AGE_W:0] key;
    logic [miq_pkg::AGE_W:0]                       key_lo;
    logic [miq_pkg::AGE_W:0]                       key_hi;
    logic [miq_pkg::AGE_W:0]                       key_win;
    logic [$clog2(miq_pkg::ENTRIES)-1:0]           win_idx;
    logic                                          pick_1;
    logic                                          pick_3;
    logic                                          pick_hi;
    logic                                          div_hold;

    assign div_hold = div_stall_exu | div_stall_idu;

    // The key puts issuable entries first and the lowest age next.
    always_comb
    begin
        for (int i = 0; i < miq_pkg::ENTRIES; i++)
            key[i] = {~(ef.ready[i] & ~(ef.funct3[i][miq_pkg::DIV_BIT] & div_hold)), ef.age[i]};
    end

    assign pick_1  = key[1] < key[0];
    assign key_lo  = pick_1 ? key[1] : key[0];
    assign pick_3  = key[3] < key[2];
    assign key_hi  = pick_3 ? key[3] : key[2];
    assign pick_hi = key_hi < key_lo;
    assign key_win = pick_hi ? key_hi : key_lo;
    assign win_idx = pick_hi ? {1'b1, pick_3} : {1'b0, pick_1};

    assign issue_vld    = ~key_win[miq_pkg::AGE_W];
    assign ef.issue_vld = grant;

    always_comb
    begin
        issue_iid       = '0;
        issue_opcode    = '0;
        issue_funct7    = '0;
        issue_funct3    = '0;
        issue_psrc1_vld = 1'b0;
        issue_psrc1     = '0;
        issue_psrc2_vld = 1'b0;
        issue_psrc2     = '0;
        issue_pdst_vld  = 1'b0;
        issue_pdst      = '0;
        for (int i = 0; i < miq_pkg::ENTRIES; i++)
        begin
            grant[i]        = issue_vld && (int'(win_idx) == i);
            issue_iid       = issue_iid | (ef.iid[i] & {miq_pkg::IID_W{grant[i]}});
            issue_opcode    = issue_opcode | (ef.opcode[i] & {miq_pkg::OPCODE_W{grant[i]}});
            issue_funct7    = issue_funct7 | (ef.funct7[i] & {miq_pkg::FUNCT7_W{grant[i]}});
            issue_funct3    = issue_funct3 | (ef.funct3[i] & {miq_pkg::FUNCT3_W{grant[i]}});
            issue_psrc1_vld = issue_psrc1_vld | (ef.psrc1_vld[i] & grant[i]);
            issue_psrc1     = issue_psrc1 | (ef.psrc1[i] & {miq_pkg::PREG_W{grant[i]}});
            issue_psrc2_vld = issue_psrc2_vld | (ef.psrc2_vld[i] & grant[i]);
            issue_psrc2     = issue_psrc2 | (ef.psrc2[i] & {miq_pkg::PREG_W{grant[i]}});
            issue_pdst_vld  = issue_pdst_vld | (ef.pdst_vld[i] & grant[i]);
            issue_pdst      = issue_pdst | (ef.pdst[i] & {miq_pkg::PREG_W{grant[i]}});
        end
    end

    a_grant_onehot: assert property (@(posedge ef.clk) $onehot0(ef.issue_vld));

    // Selection looks at ready alone and relies on empty slots never reporting ready.
    a_ready_valid: assert property (@(posedge ef.clk) (ef.ready & ~ef.vld) == '0);

endmodule

`default_nettype wire

// ==== miq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module miq_top (
    input  logic                                                clk,
    input  logic                                                rst_clk,
    input  logic                                                flush,
    input  logic                                                dispatch_vld,
    input  logic                                                dispatch_stall,
    input  logic [miq_pkg::IID_W-1:0]                           dispatch_iid,
    input  logic [miq_pkg::OPCODE_W-1:0]                        dispatch_opcode,
    input  logic [miq_pkg::FUNCT7_W-1:0]                        dispatch_funct7,
    input  logic [miq_pkg::FUNCT3_W-1:0]                        dispatch_funct3,
    input  logic                                                dispatch_psrc1_vld,
    input  logic                                                dispatch_psrc1_ready,
    input  logic [miq_pkg::PREG_W-1:0]                          dispatch_psrc1,
    input  logic                                                dispatch_psrc2_vld,
    input  logic                                                dispatch_psrc2_ready,
    input  logic [miq_pkg::PREG_W-1:0]                          dispatch_psrc2,
    input  logic                                                dispatch_pdst_vld,
    input  logic [miq_pkg::PREG_W-1:0]                          dispatch_pdst,
    input  logic [miq_pkg::WAKE_PORTS-1:0]                      wake_vld,
    input  logic [miq_pkg::WAKE_PORTS-1:0][miq_pkg::PREG_W-1:0] wake_preg,
    input  logic                                                div_stall_exu,
    input  logic                                                div_stall_idu,
    output logic                                                full,
    output logic                                                issue_vld,
    output logic [miq_pkg::IID_W-1:0]                           issue_iid,
    output logic [miq_pkg::OPCODE_W-1:0]                        issue_opcode,
    output logic [miq_pkg::FUNCT7_W-1:0]                        issue_funct7,
    output logic [miq_pkg::FUNCT3_W-1:0]                        issue_funct3,
    output logic                                                issue_psrc1_vld,
    output logic [miq_pkg::PREG_W-1:0]                          issue_psrc1,
    output logic                                                issue_psrc2_vld,
    output logic [miq_pkg::PREG_W-1:0]                          issue_psrc2,
    output logic                                                issue_pdst_vld,
    output logic [miq_pkg::PREG_W-1:0]                          issue_pdst
);

    logic [miq_pkg::ENTRIES-1:0] entry_vld;

    miq_create_if cr_if ();
    miq_entry_if  en_if (.clk(clk));

    miq_dispatch u_dispatch (
        .clk                  (clk),
        .rst_clk              (rst_clk),
        .dispatch_vld         (dispatch_vld),
        .dispatch_stall       (dispatch_stall),
        .dispatch_iid         (dispatch_iid),
        .dispatch_opcode      (dispatch_opcode),
        .dispatch_funct7      (dispatch_funct7),
        .dispatch_funct3      (dispatch_funct3),
        .dispatch_psrc1_vld   (dispatch_psrc1_vld),
        .dispatch_psrc1_ready (dispatch_psrc1_ready),
        .dispatch_psrc1       (dispatch_psrc1),
        .dispatch_psrc2_vld   (dispatch_psrc2_vld),
        .dispatch_psrc2_ready (dispatch_psrc2_ready),
        .dispatch_psrc2       (dispatch_psrc2),
        .dispatch_pdst_vld    (dispatch_pdst_vld),
        .dispatch_pdst        (dispatch_pdst),
        .entry_vld            (entry_vld),
        .full                 (full),
        .cr                   (cr_if.dispatch)
    );

    miq_entries u_entries (
        .clk       (clk),
        .rst_clk   (rst_clk),
        .flush     (flush),
        .wake_vld  (wake_vld),
        .wake_preg (wake_preg),
        .entry_vld (entry_vld),
        .cr        (cr_if.entries),
        .ef        (en_if.entries)
    );

    miq_select u_select (
        .div_stall_exu   (div_stall_exu),
        .div_stall_idu   (div_stall_idu),
        .ef              (en_if.select),
        .issue_vld       (issue_vld),
        .issue_iid       (issue_iid),
        .issue_opcode    (issue_opcode),
        .issue_funct7    (issue_funct7),
        .issue_funct3    (issue_funct3),
        .issue_psrc1_vld (issue_psrc1_vld),
        .issue_psrc1     (issue_psrc1),
        .issue_psrc2_vld (issue_psrc2_vld),
        .issue_psrc2     (issue_psrc2),
        .issue_pdst_vld  (issue_pdst_vld),
        .issue_pdst      (issue_pdst)
    );

endmodule

`default_nettype wire

// ==== tb_miq_checks.svh ====
`ifndef TB_MIQ_CHECKS_SVH
`define TB_MIQ_CHECKS_SVH

// ======================================================================
// Random source tags
// ======================================================================

// Fibonacci LFSR with taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_tag(output logic [miq_pkg::PREG_W-1:0] tag);
    tag = '0;
    for (int b = 0; b < miq_pkg::PREG_W; b++)
    begin
        lfsr_state = lfsr_step(lfsr_state);
        tag        = {tag[miq_pkg::PREG_W-2:0], lfsr_state[0]};   // One step per bit.
    end
endtask

// ======================================================================
// Compare tasks
// ======================================================================
task automatic check_full(input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("[FAIL] %0d ns: full is %b, expected %b", $time, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_issue_vld(input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("[FAIL] %0d ns: issue_vld is %b, expected %b", $time, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_issue_fields(
    input logic [miq_pkg::IID_W-1:0]    exp_iid,
    input logic [miq_pkg::OPCODE_W-1:0] exp_opcode,
    input logic [miq_pkg::FUNCT7_W-1:0] exp_funct7,
    input logic [miq_pkg::FUNCT3_W-1:0] exp_funct3,
    input logic                         exp_psrc1_vld,
    input logic [miq_pkg::PREG_W-1:0]   exp_psrc1,
    input logic                         exp_psrc2_vld,
    input logic [miq_pkg::PREG_W-1:0]   exp_psrc2,
    input logic                         exp_pdst_vld,
    input logic [miq_pkg::PREG_W-1:0]   exp_pdst
);
    if ({issue_iid, issue_opcode, issue_funct7, issue_funct3, issue_psrc1_vld, issue_psrc1,
         issue_psrc2_vld, issue_psrc2, issue_pdst_vld, issue_pdst} !==
        {exp_iid, exp_opcode, exp_funct7, exp_funct3, exp_psrc1_vld, exp_psrc1,
         exp_psrc2_vld, exp_psrc2, exp_pdst_vld, exp_pdst})
    begin
        $display("[FAIL] %0d ns: issue fields iid %h op %h f7 %h f3 %h s1 %b/%h s2 %b/%h d %b/%h",
                 $time, issue_iid, issue_opcode, issue_funct7, issue_funct3, issue_psrc1_vld,
                 issue_psrc1, issue_psrc2_vld, issue_psrc2, issue_pdst_vld, issue_pdst);
        $display("       expected iid %h op %h f7 %h f3 %h s1 %b/%h s2 %b/%h d %b/%h",
                 exp_iid, exp_opcode, exp_funct7, exp_funct3, exp_psrc1_vld, exp_psrc1,
                 exp_psrc2_vld, exp_psrc2, exp_pdst_vld, exp_pdst);
        stop_with_failure();
    end
endtask

`endif

// ==== tb_miq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_miq;

    localparam int          RESET_CYCLES = 10;
    localparam int          MAX_LINES    = 200;   // Guard on the pattern read loop.
    localparam int          NUM_IIDS     = 2 ** miq_pkg::IID_W;
    localparam logic [31:0] LFSR_SEED    = 32'h8a0a6683;
    localparam logic [miq_pkg::OPCODE_W-1:0] OP_MULDIV = 7'h33;   // OP major opcode.
    localparam logic [miq_pkg::FUNCT7_W-1:0] F7_MULDIV = 7'h01;   // M extension funct7.

    logic                                                clk;
    logic                                                rst_clk;
    logic                                                flush;
    logic                                                dispatch_vld;
    logic                                                dispatch_stall;
    logic [miq_pkg::IID_W-1:0]                           dispatch_iid;
    logic [miq_pkg::OPCODE_W-1:0]                        dispatch_opcode;
    logic [miq_pkg::FUNCT7_W-1:0]                        dispatch_funct7;
    logic [miq_pkg::FUNCT3_W-1:0]                        dispatch_funct3;
    logic                                                dispatch_psrc1_vld;
    logic                                                dispatch_psrc1_ready;
    logic [miq_pkg::PREG_W-1:0]                          dispatch_psrc1;
    logic                                                dispatch_psrc2_vld;
    logic                                                dispatch_psrc2_ready;
    logic [miq_pkg::PREG_W-1:0]                          dispatch_psrc2;
    logic                                                dispatch_pdst_vld;
    logic [miq_pkg::PREG_W-1:0]                          dispatch_pdst;
    logic [miq_pkg::WAKE_PORTS-1:0]                      wake_vld;
    logic [miq_pkg::WAKE_PORTS-1:0][miq_pkg::PREG_W-1:0] wake_preg;
    logic                                                div_stall_exu;
    logic                                                div_stall_idu;
    logic                                                full;
    logic                                                issue_vld;
    logic [miq_pkg::IID_W-1:0]                           issue_iid;
    logic [miq_pkg::OPCODE_W-1:0]                        issue_opcode;
    logic [miq_pkg::FUNCT7_W-1:0]                        issue_funct7;
    logic [miq_pkg::FUNCT3_W-1:0]                        issue_funct3;
    logic                                                issue_psrc1_vld;
    logic [miq_pkg::PREG_W-1:0]                          issue_psrc1;
    logic                                                issue_psrc2_vld;
    logic [miq_pkg::PREG_W-1:0]                          issue_psrc2;
    logic                                                issue_pdst_vld;
    logic [miq_pkg::PREG_W-1:0]                          issue_pdst;

    // Payload of every dispatch kept by instruction id for the issue checks.
    logic [miq_pkg::FUNCT3_W-1:0] rec_funct3    [NUM_IIDS];
    logic                         rec_psrc1_vld [NUM_IIDS];
    logic [miq_pkg::PREG_W-1:0]   rec_psrc1     [NUM_IIDS];
    logic                         rec_psrc2_vld [NUM_IIDS];
    logic [miq_pkg::PREG_W-1:0]   rec_psrc2     [NUM_IIDS];

    logic [31:0] lfsr_state;
    logic [31:0] f_flush, f_dvld, f_dstall, f_iid, f_f3, f_rnd, f_stl;
    logic [31:0] f_s1v, f_s1r, f_s1, f_s2v, f_s2r, f_s2;
    logic [31:0] f_wv, f_wp0, f_wp1;
    logic [31:0] e_full, e_ivld, e_iid;
    int          fd;
    int          code;
    int          n_read;
    int          n_cycles;
    string       line;

    miq_top DUT (.*);

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "Simulation stopped.");
    endtask

`include "tb_miq_checks.svh"

    // ==================================================================
    // Per-cycle drive and check
    // ==================================================================
    task automatic drive_cycle();
        flush                = f_flush[0];
        dispatch_vld         = f_dvld[0];
        dispatch_stall       = f_dstall[0];
        dispatch_iid         = f_iid[miq_pkg::IID_W-1:0];
        dispatch_opcode      = OP_MULDIV;
        dispatch_funct7      = F7_MULDIV;
        dispatch_funct3      = f_f3[miq_pkg::FUNCT3_W-1:0];
        dispatch_psrc1_vld   = f_s1v[0];
        dispatch_psrc1_ready = f_s1r[0];
        dispatch_psrc2_vld   = f_s2v[0];
        dispatch_psrc2_ready = f_s2r[0];
        if (f_rnd[0])
        begin
            draw_tag(dispatch_psrc1);   // Filler entry whose tags do not matter.
            draw_tag(dispatch_psrc2);
        end
        else
        begin
            dispatch_psrc1 = f_s1[miq_pkg::PREG_W-1:0];
            dispatch_psrc2 = f_s2[miq_pkg::PREG_W-1:0];
        end
        dispatch_pdst_vld = 1'b1;
        dispatch_pdst     = {1'b1, f_iid[miq_pkg::IID_W-1:0]};
        wake_vld          = f_wv[miq_pkg::WAKE_PORTS-1:0];
        wake_preg[0]      = f_wp0[miq_pkg::PREG_W-1:0];
        wake_preg[1]      = f_wp1[miq_pkg::PREG_W-1:0];
        div_stall_exu     = f_stl[1];
        div_stall_idu     = f_stl[0];
        if (dispatch_vld)
        begin
            rec_funct3[dispatch_iid]    = dispatch_funct3;
            rec_psrc1_vld[dispatch_iid] = dispatch_psrc1_vld;
            rec_psrc1[dispatch_iid]     = dispatch_psrc1;
            rec_psrc2_vld[dispatch_iid] = dispatch_psrc2_vld;
            rec_psrc2[dispatch_iid]     = dispatch_psrc2;
        end
    endtask

    task automatic check_cycle();
        logic [miq_pkg::IID_W-1:0] id;
        id = e_iid[miq_pkg::IID_W-1:0];
        check_full(full, e_full[0]);
        check_issue_vld(issue_vld, e_ivld[0]);
        if (e_ivld[0])
            check_issue_fields(id, OP_MULDIV, F7_MULDIV, rec_funct3[id],
                               rec_psrc1_vld[id], rec_psrc1[id],
                               rec_psrc2_vld[id], rec_psrc2[id],
                               1'b1, {1'b1, id});
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst_clk              = 1'b0;
        flush                = 1'b0;
        dispatch_vld         = 1'b0;
        dispatch_stall       = 1'b0;
        dispatch_iid         = '0;
        dispatch_opcode      = '0;
        dispatch_funct7      = '0;
        dispatch_funct3      = '0;
        dispatch_psrc1_vld   = 1'b0;
        dispatch_psrc1_ready = 1'b0;
        dispatch_psrc1       = '0;
        dispatch_psrc2_vld   = 1'b0;
        dispatch_psrc2_ready = 1'b0;
        dispatch_psrc2       = '0;
        dispatch_pdst_vld    = 1'b0;
        dispatch_pdst        = '0;
        wake_vld             = '0;
        wake_preg            = '0;
        div_stall_exu        = 1'b0;
        div_stall_idu        = 1'b0;
        lfsr_state           = LFSR_SEED;

        for (int c = 0; c < RESET_CYCLES; c++)
            @(posedge clk);
        #1;
        rst_clk = 1'b1;

        fd = $fopen("miq_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the pattern file miq_patterns.txt.");
            stop_with_failure();
        end
        n_read   = 0;
        n_cycles = 0;
        while (!$feof(fd))
        begin
            if (n_read >= MAX_LINES)
            begin
                $display("Timed out after %0d pattern lines without reaching the file end.",
                         MAX_LINES);
                stop_with_failure();
            end
            code = $fgets(line, fd);
            n_read++;
            if (code > 0 && line.len() > 1 && line.getc(0) != "#")
            begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               f_flush, f_dvld, f_dstall, f_iid, f_f3, f_s1v, f_s1r, f_s1,
                               f_s2v, f_s2r, f_s2, f_rnd, f_wv, f_wp0, f_wp1, f_stl,
                               e_full, e_ivld, e_iid);
                if (code != 19)
                begin
                    $display("Pattern line %0d does not hold 19 hex columns.", n_read);
                    stop_with_failure();
                end
                @(posedge clk);
                #1;
                drive_cycle();
                #8;   // Just before the next rising edge.
                check_cycle();
                n_cycles++;
            end
        end
        $fclose(fd);

        if (n_cycles == 0)
        begin
            $display("No stimulus lines were found in the pattern file.");
            stop_with_failure();
        end
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== miq_patterns.txt ====
# fl dv ds iid f3 s1v s1r s1 s2v s2r s2 rnd wv wp0 wp1 stl   then expected: full ivld iid
# All hex. rnd=1 takes both source tags from the LFSR. stl is {div_stall_exu, div_stall_idu}.
0 1 0 01 0 1 1 05 1 1 06 0 0 00 00 0  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 1 01
0 1 0 02 0 1 0 0a 0 0 00 0 0 00 00 0  0 0 00
0 1 0 03 1 1 0 0b 0 0 00 0 0 00 00 0  0 0 00
0 1 0 04 0 1 0 0c 0 0 00 0 0 00 00 0  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 1 0c 00 0  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 1 0b 00 0  0 1 04
0 0 0 00 0 0 0 00 0 0 00 0 2 00 0a 0  0 1 03
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 1 02
0 1 0 08 0 1 0 20 0 0 00 0 0 00 00 0  0 0 00
0 1 0 09 0 1 0 21 0 0 00 0 0 00 00 0  0 0 00
0 1 0 0a 0 1 0 22 0 0 00 0 0 00 00 0  0 0 00
0 1 0 0b 0 1 0 23 0 0 00 0 0 00 00 0  0 0 00
0 1 0 0c 0 1 1 24 0 0 00 0 0 00 00 0  1 0 00
0 0 0 00 0 0 0 00 0 0 00 0 1 20 00 0  1 0 00
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  1 1 08
0 0 0 00 0 0 0 00 0 0 00 0 3 21 22 0  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 1 23 00 0  0 1 09
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 1 0a
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 1 0b
0 1 0 0d 4 1 1 25 1 1 26 0 0 00 00 2  0 0 00
0 1 0 0e 0 1 1 00 1 1 00 1 0 00 00 2  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 1  0 1 0e
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 1  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 1 0d
0 1 0 10 0 1 0 30 0 0 00 0 0 00 00 0  0 0 00
0 1 0 11 2 1 1 00 1 1 00 1 0 00 00 0  0 0 00
0 1 0 12 5 1 0 30 0 0 00 0 0 00 00 0  0 1 11
0 1 0 13 0 1 0 30 0 0 00 0 0 00 00 0  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 1 30 00 0  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 1 10
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 1 12
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 1 13
0 1 0 14 0 1 0 31 0 0 00 0 0 00 00 0  0 0 00
0 1 0 15 0 1 0 32 0 0 00 0 0 00 00 0  0 0 00
0 1 0 16 0 1 0 33 0 0 00 0 0 00 00 0  0 0 00
0 1 0 17 0 1 0 34 0 0 00 0 3 31 32 0  0 0 00
1 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  1 1 14
1 1 0 18 0 1 1 35 1 1 36 0 0 00 00 0  0 0 00
0 0 0 00 0 0 0 00 0 0 00 0 0 00 00 0  0 0 00

// ==== vlog.f ====
+incdir+.
miq_pkg.sv
miq_create_if.sv
miq_entry_if.sv
miq_dispatch.sv
miq_entries.sv
miq_select.sv
miq_top.sv
tb_miq.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the issue queue testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_miq
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_miq 2>&1)
status=$?
echo "$output"
echo "Simulator exit status: $status"

if echo "$output" | grep -qxF "All checks passed"; then
    exit 0
else
    exit 1
fi
